// File: source/mapper_pkg.sv
package mapper_pkg;

    // Mapper selection from the slot configuration word
    typedef enum logic [2:0] {
        MAPPER_NONE       = 3'd0,
        MAPPER_ASCII8     = 3'd1,
        MAPPER_ASCII16    = 3'd2,
        MAPPER_KONAMI     = 3'd3,
        MAPPER_KONAMI_SCC = 3'd4
    } mapper_typ_e;

    // Devices that can sit behind a slot
    typedef enum logic {
        DEV_NONE = 1'b0,
        DEV_SCC  = 1'b1
    } device_typ_e;

    // CPU side of one bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;   // Write data
        logic        mreq;
        logic        rd;
        logic        wr;
    } cpu_bus_t;

    typedef struct packed {
        mapper_typ_e typ;
        device_typ_e device;
    } block_info_t;

    // One mapper's share of the memory bus
    typedef struct packed {
        logic [19:0] addr;   // ROM byte address
        logic        rnw;
        logic        ram_cs;
    } mapper_out_t;

    // Unselected mappers drive this so the AND/OR merge is transparent
    localparam mapper_out_t MAPPER_IDLE = '{
        addr:   20'hF_FFFF,
        rnw:    1'b1,
        ram_cs: 1'b0
    };

    typedef struct packed {
        device_typ_e typ;
        logic        en;
        logic        we;
    } device_bus_t;

    // External memory bus with the same layout as mapper_out_t
    typedef struct packed {
        logic [19:0] addr;
        logic        rnw;
        logic        ram_cs;
    } memory_bus_t;

endpackage

// File: source/mapper_ascii8.sv
`timescale 1ns/1ps

module mapper_ascii8 import mapper_pkg::*; #(
    parameter int ROM_ADDR_W = 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu_bus,
    input  block_info_t block_info,
    output mapper_out_t out
);

    // Keeps only the ROM address bits that exist
    localparam logic [19:0] ADDR_MASK = 20'((21'd1 << ROM_ADDR_W) - 21'd1);

    logic [3:0][7:0] bank;      // One bank per 8 KB window
    logic            sel;
    logic            in_page;
    logic [1:0]      win;
    logic            bank_we;
    logic [19:0]     rom_addr;

    assign sel = block_info.typ == MAPPER_ASCII8;

    // Pages 1 and 2 only (0x4000-0xBFFF)
    assign in_page = cpu_bus.addr[15] ^ cpu_bus.addr[14];

    // 0x4000 -> 0, 0x6000 -> 1, 0x8000 -> 2, 0xA000 -> 3
    assign win = {~cpu_bus.addr[14], cpu_bus.addr[13]};

    // Bank registers sit 2 KB apart in 0x6000-0x7FFF
    assign bank_we = sel && cpu_bus.mreq && cpu_bus.wr
                     && cpu_bus.addr[15:13] == 3'b011;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank <= '0;
        end else if (bank_we) begin
            bank[cpu_bus.addr[12:11]] <= cpu_bus.data;
        end
    end

    assign rom_addr = {bank[win][6:0], cpu_bus.addr[12:0]} & ADDR_MASK;

    always_comb begin
        out = MAPPER_IDLE;
        if (sel && cpu_bus.mreq && cpu_bus.rd && in_page) begin
            out.addr   = rom_addr;
            out.rnw    = 1'b1;
            out.ram_cs = 1'b1;
        end
    end

endmodule

// File: source/mapper_ascii16.sv
`timescale 1ns/1ps

module mapper_ascii16 import mapper_pkg::*; #(
    parameter int ROM_ADDR_W = 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu_bus,
    input  block_info_t block_info,
    output mapper_out_t out
);

    localparam logic [19:0] ADDR_MASK = 20'((21'd1 << ROM_ADDR_W) - 21'd1);

    logic [1:0][7:0] bank;      // Banks for 0x4000 and 0x8000
    logic            sel;
    logic            in_page;
    logic            win;
    logic            bank_we;
    logic [19:0]     rom_addr;

    assign sel     = block_info.typ == MAPPER_ASCII16;
    assign in_page = cpu_bus.addr[15] ^ cpu_bus.addr[14];
    assign win     = cpu_bus.addr[15];  // 16 KB window index

    // Bit 12 picks the bank in 0x6000-0x67FF and 0x7000-0x77FF
    assign bank_we = sel && cpu_bus.mreq && cpu_bus.wr
                     && cpu_bus.addr[15:13] == 3'b011 && !cpu_bus.addr[11];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank <= '0;
        end else if (bank_we) begin
            bank[cpu_bus.addr[12]] <= cpu_bus.data;
        end
    end

    assign rom_addr = {bank[win][5:0], cpu_bus.addr[13:0]} & ADDR_MASK;

    always_comb begin
        out = MAPPER_IDLE;
        if (sel && cpu_bus.mreq && cpu_bus.rd && in_page) begin
            out.addr   = rom_addr;
            out.rnw    = 1'b1;
            out.ram_cs = 1'b1;
        end
    end

endmodule

// File: source/mapper_konami.sv
`timescale 1ns/1ps

module mapper_konami import mapper_pkg::*; #(
    parameter int ROM_ADDR_W = 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu_bus,
    input  block_info_t block_info,
    output mapper_out_t out
);

    localparam logic [19:0] ADDR_MASK = 20'((21'd1 << ROM_ADDR_W) - 21'd1);

    logic [2:0][7:0] bank;      // Windows 1 to 3 since window 0 is hardwired
    logic            sel;
    logic            in_page;
    logic [1:0]      win;
    logic [1:0]      win_m1;
    logic            bank_we;
    logic [7:0]      cur_bank;
    logic [19:0]     rom_addr;

    assign sel     = block_info.typ == MAPPER_KONAMI;
    assign in_page = cpu_bus.addr[15] ^ cpu_bus.addr[14];
    assign win     = {~cpu_bus.addr[14], cpu_bus.addr[13]};
    assign win_m1  = win - 2'd1;

    // Any write inside windows 1 to 3 switches that window
    assign bank_we = sel && cpu_bus.mreq && cpu_bus.wr && in_page && win != 2'd0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank <= {8'd3, 8'd2, 8'd1};
        end else if (bank_we) begin
            bank[win_m1] <= cpu_bus.data;
        end
    end

    assign cur_bank = (win == 2'd0) ? 8'd0 : bank[win_m1];
    assign rom_addr = {cur_bank[6:0], cpu_bus.addr[12:0]} & ADDR_MASK;

    always_comb begin
        out = MAPPER_IDLE;
        if (sel && cpu_bus.mreq && cpu_bus.rd && in_page) begin
            out.addr   = rom_addr;
            out.rnw    = 1'b1;
            out.ram_cs = 1'b1;
        end
    end

endmodule

// File: source/mapper_konami_scc.sv
`timescale 1ns/1ps

module mapper_konami_scc import mapper_pkg::*; #(
    parameter int ROM_ADDR_W = 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu_bus,
    input  block_info_t block_info,
    output mapper_out_t out,
    output device_bus_t device_out
);

    localparam logic [19:0] ADDR_MASK = 20'((21'd1 << ROM_ADDR_W) - 21'd1);

    logic [3:0][7:0] bank;
    logic            sel;
    logic            in_page;
    logic [1:0]      win;
    logic            bank_we;
    logic            scc_on;    // Bank 2 maps the SCC registers
    logic            scc_hit;
    logic [19:0]     rom_addr;

    assign sel     = block_info.typ == MAPPER_KONAMI_SCC;
    assign in_page = cpu_bus.addr[15] ^ cpu_bus.addr[14];
    assign win     = {~cpu_bus.addr[14], cpu_bus.addr[13]};

    // Each register spans 2 KB at 0x5000, 0x7000, 0x9000 and 0xB000
    assign bank_we = sel && cpu_bus.mreq && cpu_bus.wr && in_page
                     && cpu_bus.addr[12:11] == 2'b10;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank <= {8'd3, 8'd2, 8'd1, 8'd0};
        end else if (bank_we) begin
            bank[win] <= cpu_bus.data;
        end
    end

    assign scc_on = bank[2][5:0] == 6'h3F;

    // 0x9800-0x9FFF while the SCC is mapped in
    assign scc_hit = sel && scc_on && cpu_bus.mreq
                     && cpu_bus.addr[15:11] == 5'b10011;

    assign rom_addr = {bank[win][6:0], cpu_bus.addr[12:0]} & ADDR_MASK;

    always_comb begin
        out = MAPPER_IDLE;
        if (sel && cpu_bus.mreq && cpu_bus.rd && in_page && !scc_hit) begin
            out.addr   = rom_addr;
            out.rnw    = 1'b1;
            out.ram_cs = 1'b1;
        end
    end

    // Type is filled in by the top level
    always_comb begin
        device_out.typ = DEV_NONE;
        device_out.en  = scc_hit;
        device_out.we  = scc_hit && cpu_bus.wr;
    end

endmodule

// File: source/mappers.sv
`timescale 1ns/1ps

module mappers import mapper_pkg::*; #(
    parameter int ROM_ADDR_W = 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu_bus,
    input  block_info_t block_info,
    output memory_bus_t memory_bus,
    output device_bus_t device_bus
);

    mapper_out_t ascii8_out;
    mapper_out_t ascii16_out;
    mapper_out_t konami_out;
    mapper_out_t konami_scc_out;
    device_bus_t konami_scc_device_out;  // SCC register window

    mapper_ascii8 #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) ascii8 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .out        (ascii8_out)
    );

    mapper_ascii16 #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) ascii16 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .out        (ascii16_out)
    );

    mapper_konami #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) konami (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .out        (konami_out)
    );

    mapper_konami_scc #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) konami_scc (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .out        (konami_scc_out),
        .device_out (konami_scc_device_out)
    );

    // Idle mappers drive all ones, so AND leaves the active one
    assign memory_bus.addr = ascii8_out.addr
                           & ascii16_out.addr
                           & konami_out.addr
                           & konami_scc_out.addr;

    assign memory_bus.rnw = ascii8_out.rnw & ascii16_out.rnw
                          & konami_out.rnw & konami_scc_out.rnw;

    assign memory_bus.ram_cs = ascii8_out.ram_cs | ascii16_out.ram_cs
                             | konami_out.ram_cs | konami_scc_out.ram_cs;

    assign device_bus.typ = cpu_bus.mreq ? block_info.device : DEV_NONE;
    assign device_bus.en  = konami_scc_device_out.en;
    assign device_bus.we  = konami_scc_device_out.we;

endmodule

// File: test/mapper_model.svh
`ifndef MAPPER_MODEL_SVH
`define MAPPER_MODEL_SVH

localparam logic [31:0] ADDR_MASK = (32'd1 << ROM_ADDR_W) - 32'd1;

// Expected memory and device bus for one cycle
typedef struct packed {
    memory_bus_t mem;
    device_bus_t dev;
} expect_t;

logic [7:0] a8_bank  [4];
logic [7:0] a16_bank [2];
logic [7:0] kon_bank [4];   // Entry 0 is never written
logic [7:0] scc_bank [4];

function automatic logic in_range(input logic [15:0] addr, input logic [15:0] lo,
                                  input logic [15:0] hi);
    return addr >= lo && addr <= hi;
endfunction

task automatic reset_model();
    a8_bank  = '{8'd0, 8'd0, 8'd0, 8'd0};
    a16_bank = '{8'd0, 8'd0};
    kon_bank = '{8'd0, 8'd1, 8'd2, 8'd3};
    scc_bank = '{8'd0, 8'd1, 8'd2, 8'd3};
endtask

// Bank register writes with one rule per mapper type
task automatic apply_write(input cpu_bus_t cpu, input block_info_t info);
    if (cpu.mreq && cpu.wr) begin
        case (info.typ)
            MAPPER_ASCII8: begin
                if (in_range(cpu.addr, 16'h6000, 16'h7FFF))
                    a8_bank[2'((cpu.addr - 16'h6000) >> 11)] = cpu.data;  // 2 KB per register
            end
            MAPPER_ASCII16: begin
                if (in_range(cpu.addr, 16'h6000, 16'h67FF))
                    a16_bank[0] = cpu.data;
                else if (in_range(cpu.addr, 16'h7000, 16'h77FF))
                    a16_bank[1] = cpu.data;
            end
            MAPPER_KONAMI: begin
                if (in_range(cpu.addr, 16'h6000, 16'hBFFF))
                    kon_bank[2'((cpu.addr - 16'h4000) >> 13)] = cpu.data;
            end
            MAPPER_KONAMI_SCC: begin
                if (in_range(cpu.addr, 16'h5000, 16'h57FF))
                    scc_bank[0] = cpu.data;
                else if (in_range(cpu.addr, 16'h7000, 16'h77FF))
                    scc_bank[1] = cpu.data;
                else if (in_range(cpu.addr, 16'h9000, 16'h97FF))
                    scc_bank[2] = cpu.data;
                else if (in_range(cpu.addr, 16'hB000, 16'hB7FF))
                    scc_bank[3] = cpu.data;
            end
            default: ;
        endcase
    end
endtask

function automatic expect_t expected_out(input cpu_bus_t cpu, input block_info_t info);
    expect_t     e;
    logic        scc_hit;
    logic        hit;
    logic [31:0] bank;
    logic [31:0] win_size;
    logic [1:0]  win;
    e.mem.addr   = 20'hF_FFFF;   // Idle pattern
    e.mem.rnw    = 1'b1;
    e.mem.ram_cs = 1'b0;
    e.dev.typ    = cpu.mreq ? info.device : DEV_NONE;
    scc_hit = info.typ == MAPPER_KONAMI_SCC && scc_bank[2][5:0] == 6'h3F
              && cpu.mreq && in_range(cpu.addr, 16'h9800, 16'h9FFF);
    e.dev.en = scc_hit;
    e.dev.we = scc_hit && cpu.wr;
    hit      = cpu.mreq && cpu.rd && in_range(cpu.addr, 16'h4000, 16'hBFFF) && !scc_hit;
    win      = 2'((cpu.addr - 16'h4000) >> 13);   // 8 KB window number
    win_size = 32'd8192;
    bank     = 32'd0;
    case (info.typ)
        MAPPER_ASCII8:     bank = 32'(a8_bank[win]);
        MAPPER_ASCII16: begin
            win_size = 32'd16384;
            bank     = 32'(a16_bank[win[1]]);
        end
        MAPPER_KONAMI:     bank = (win == 2'd0) ? 32'd0 : 32'(kon_bank[win]);
        MAPPER_KONAMI_SCC: bank = 32'(scc_bank[win]);
        default:           hit = 1'b0;
    endcase
    if (hit) begin
        e.mem.addr   = 20'((bank * win_size + 32'(cpu.addr) % win_size) & ADDR_MASK);
        e.mem.ram_cs = 1'b1;
    end
    return e;
endfunction

`endif

// File: test/tb_mappers.sv
`timescale 1ns/1ps

module tb_mappers import mapper_pkg::*;;

    localparam int ROM_ADDR_W = 20;
    localparam int MAX_CYCLES = 4000;   // About twice the stimulus length

    `include "mapper_model.svh"

    logic        clk = 1'b0;
    logic        rst_n;
    cpu_bus_t    cpu_bus;
    block_info_t block_info;
    memory_bus_t memory_bus;
    device_bus_t device_bus;

    int          seed;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    device_typ_e slot_device;
    expect_t     expect_now;

    mappers #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .memory_bus (memory_bus),
        .device_bus (device_bus)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [7:0] random_byte();
        return 8'(next_random());
    endfunction

    function automatic logic [15:0] random_addr(input logic [15:0] lo, input logic [15:0] hi);
        logic [31:0] span;
        span = 32'(hi) - 32'(lo) + 32'd1;
        return 16'(32'(lo) + next_random() % span);
    endfunction

    function automatic mapper_typ_e random_type();
        return mapper_typ_e'(3'(next_random() % 32'd5));
    endfunction

    function automatic device_typ_e random_device();
        return device_typ_e'(1'(next_random()));
    endfunction

    // One CPU cycle driven just after the rising edge
    task automatic drive_cycle(input mapper_typ_e typ, input logic [15:0] addr,
                               input logic [7:0] data, input logic mreq,
                               input logic rd, input logic wr);
        @(posedge clk);
        #1;
        block_info.typ    = typ;
        block_info.device = slot_device;
        cpu_bus.addr      = addr;
        cpu_bus.data      = data;
        cpu_bus.mreq      = mreq;
        cpu_bus.rd        = rd;
        cpu_bus.wr        = wr;
    endtask

    task automatic bus_read(input mapper_typ_e typ, input logic [15:0] addr);
        drive_cycle(typ, addr, random_byte(), 1'b1, 1'b1, 1'b0);
    endtask

    task automatic bus_write(input mapper_typ_e typ, input logic [15:0] addr,
                             input logic [7:0] data);
        drive_cycle(typ, addr, data, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic read_all_windows(input mapper_typ_e typ, input int per_window);
        logic [15:0] base;
        for (int w = 0; w < 4; w++) begin
            base = 16'h4000 + 16'(w) * 16'h2000;
            repeat (per_window) bus_read(typ, random_addr(base, base + 16'h1FFF));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
            $display("Summary: %0d cycles checked, %0d errors", checks, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    // Compare at the falling edge and then advance the model
    always @(negedge clk) begin
        expect_now = expected_out(cpu_bus, block_info);
        checks = checks + 1;
        if (memory_bus.addr !== expect_now.mem.addr) begin
            errors = errors + 1;
            $display("mismatch memory_bus.addr: got %h, expected %h (cycle %0d)",
                     memory_bus.addr, expect_now.mem.addr, cycles);
        end
        if (memory_bus.rnw !== expect_now.mem.rnw) begin
            errors = errors + 1;
            $display("mismatch memory_bus.rnw: got %h, expected %h (cycle %0d)",
                     memory_bus.rnw, expect_now.mem.rnw, cycles);
        end
        if (memory_bus.ram_cs !== expect_now.mem.ram_cs) begin
            errors = errors + 1;
            $display("mismatch memory_bus.ram_cs: got %h, expected %h (cycle %0d)",
                     memory_bus.ram_cs, expect_now.mem.ram_cs, cycles);
        end
        if (device_bus.typ !== expect_now.dev.typ) begin
            errors = errors + 1;
            $display("mismatch device_bus.typ: got %h, expected %h (cycle %0d)",
                     device_bus.typ, expect_now.dev.typ, cycles);
        end
        if (device_bus.en !== expect_now.dev.en) begin
            errors = errors + 1;
            $display("mismatch device_bus.en: got %h, expected %h (cycle %0d)",
                     device_bus.en, expect_now.dev.en, cycles);
        end
        if (device_bus.we !== expect_now.dev.we) begin
            errors = errors + 1;
            $display("mismatch device_bus.we: got %h, expected %h (cycle %0d)",
                     device_bus.we, expect_now.dev.we, cycles);
        end
        if (!rst_n)
            reset_model();
        else
            apply_write(cpu_bus, block_info);
    end

    initial begin
        logic [7:0] bank_val;
        logic       rd_bit;
        seed        = 32'h4a5c;
        rst_n       = 1'b0;
        cpu_bus     = '0;
        block_info  = '{typ: MAPPER_NONE, device: DEV_NONE};
        slot_device = DEV_NONE;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Default banks straight after reset
        read_all_windows(MAPPER_ASCII8, 1);
        read_all_windows(MAPPER_ASCII16, 1);
        read_all_windows(MAPPER_KONAMI, 1);
        read_all_windows(MAPPER_KONAMI_SCC, 1);

        repeat (80) begin
            bus_write(MAPPER_ASCII8, random_addr(16'h6000, 16'h7FFF), random_byte());
            read_all_windows(MAPPER_ASCII8, 1);
        end
        repeat (80) begin
            bus_write(MAPPER_ASCII16, random_addr(16'h6000, 16'h7FFF), random_byte());
            read_all_windows(MAPPER_ASCII16, 1);
        end

        // Konami writes also hit window 0 which must ignore them
        repeat (60) begin
            bus_write(MAPPER_KONAMI, random_addr(16'h4000, 16'hBFFF), random_byte());
            read_all_windows(MAPPER_KONAMI, 1);
        end

        slot_device = DEV_SCC;
        repeat (20) begin
            bus_write(MAPPER_KONAMI_SCC, random_addr(16'h9000, 16'h97FF),
                      8'h3F | (random_byte() & 8'hC0));
            repeat (3) begin
                bus_read(MAPPER_KONAMI_SCC, random_addr(16'h9800, 16'h9FFF));
                bus_write(MAPPER_KONAMI_SCC, random_addr(16'h9800, 16'h9FFF), random_byte());
            end
            bus_write(MAPPER_KONAMI_SCC, random_addr(16'h5000, 16'h57FF), random_byte());
            bus_write(MAPPER_KONAMI_SCC, random_addr(16'h7000, 16'h77FF), random_byte());
            bus_write(MAPPER_KONAMI_SCC, random_addr(16'hB000, 16'hB7FF), random_byte());
            bank_val = random_byte();
            if (bank_val[5:0] == 6'h3F)
                bank_val[0] = 1'b0;   // Any other value closes the SCC window
            bus_write(MAPPER_KONAMI_SCC, random_addr(16'h9000, 16'h97FF), bank_val);
            repeat (2) begin
                bus_read(MAPPER_KONAMI_SCC, random_addr(16'h9800, 16'h9FFF));
                bus_write(MAPPER_KONAMI_SCC, random_addr(16'h9800, 16'h9FFF), random_byte());
            end
            read_all_windows(MAPPER_KONAMI_SCC, 1);
        end

        // Idle cases with no mapper, outside the pages or without mreq
        repeat (40) begin
            slot_device = random_device();
            bus_read(MAPPER_NONE, random_addr(16'h0000, 16'hFFFF));
        end
        repeat (40) begin
            slot_device = random_device();
            if (next_random() % 32'd2 == 32'd0)
                bus_read(random_type(), random_addr(16'h0000, 16'h3FFF));
            else
                bus_read(random_type(), random_addr(16'hC000, 16'hFFFF));
        end
        repeat (40) begin
            slot_device = random_device();
            drive_cycle(random_type(), random_addr(16'h0000, 16'hFFFF), random_byte(),
                        1'b0, 1'b1, 1'b0);
        end

        // Mapper type changes every cycle
        repeat (400) begin
            slot_device = random_device();
            case (next_random() % 32'd3)
                32'd0: bus_read(random_type(), random_addr(16'h4000, 16'hBFFF));
                32'd1: bus_write(random_type(), random_addr(16'h4000, 16'hBFFF), random_byte());
                default: begin
                    rd_bit = 1'(next_random());
                    drive_cycle(random_type(), random_addr(16'h0000, 16'hFFFF), random_byte(),
                                1'(next_random()), rd_bit, !rd_bit);
                end
            endcase
        end
        slot_device = DEV_NONE;
        read_all_windows(MAPPER_ASCII8, 2);
        read_all_windows(MAPPER_ASCII16, 2);
        read_all_windows(MAPPER_KONAMI, 2);
        read_all_windows(MAPPER_KONAMI_SCC, 2);

        @(posedge clk);
        #1;
        cpu_bus.mreq = 1'b0;
        @(negedge clk);
        #1;
        $display("Summary: %0d cycles checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+test
source/mapper_pkg.sv
source/mapper_ascii8.sv
source/mapper_ascii16.sv
source/mapper_konami.sv
source/mapper_konami_scc.sv
source/mappers.sv
test/tb_mappers.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_mappers -f all.f -o tb_mappers

out=$(./obj_dir/tb_mappers)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi
